/* list.f */
common/crtc_regs_pkg.sv
common/video_pkg.sv
common/display_cfg_if.sv
crtc/crtc_registers.sv
crtc/raster_timing.sv
crtc/cursor_color.sv
verilog/display_top.sv
test/display_asserts.sv
test/tb_display_top.sv

/* test/tb_display_top.sv */
module tb_display_top
    import crtc_regs_pkg::*, video_pkg::*;
();

    localparam bus_addr_t REG_BASE = 19'h001e8;
    localparam int ACK_TIMEOUT = 8;
    localparam int FRAME_TIMEOUT = 3 * H_TOTAL * V_TOTAL;
    localparam int VISIBLE_PIXELS = H_VISIBLE * V_VISIBLE;
    localparam int CURSOR_CELL = 33;
    localparam int CURSOR_START = 2;
    localparam int CURSOR_END = 4;

    logic clk;
    logic reset;
    logic cs;
    logic access;
    logic wr_en;
    bus_addr_t addr;
    logic [1:0] bytesel;
    bus_data_t data_in;
    bus_data_t data_out;
    logic ack;
    logic hsync;
    logic vsync;
    logic display_enable;
    color_t pixel_color;
    logic graphics_enabled;
    logic bright_colors;
    logic palette_sel;

    // expected register contents, stored already masked to their readable fields
    reg_byte_t crtc_model [16];
    reg_byte_t mode_model;
    reg_byte_t color_model;
    crtc_index_t index_model;

    display_top u_display_top (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .access(access),
        .wr_en(wr_en),
        .addr(addr),
        .bytesel(bytesel),
        .data_in(data_in),
        .data_out(data_out),
        .ack(ack),
        .hsync(hsync),
        .vsync(vsync),
        .display_enable(display_enable),
        .pixel_color(pixel_color),
        .graphics_enabled(graphics_enabled),
        .bright_colors(bright_colors),
        .palette_sel(palette_sel)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            stop_on_failure($sformatf("ERROR %s actual 0x%0h expected 0x%0h",
                                      name, actual, expected));
    endtask

    always @(posedge clk) begin
        if (u_display_top.u_display_asserts.failures != 0)
            stop_on_failure("a concurrent assertion on the display outputs failed");
    end

    // readable bits of each CRTC register behind the index/value pair
    function automatic reg_byte_t index_mask(input crtc_index_t idx);
        case (idx)
            IDX_CURSOR_START: return 8'h37;
            IDX_CURSOR_END: return 8'h07;
            IDX_CURSOR_HI: return 8'h7f;
            IDX_CURSOR_LO: return 8'hff;
            default: return 8'h00;
        endcase
    endfunction

    // one bus access held until ack, which must come exactly one clock later
    task automatic bus_cycle(input logic write, input logic [2:0] ofs, input logic [1:0] sel,
                             input bus_data_t wdata, output bus_data_t rdata);
        int waited;
        @(posedge clk);
        cs <= 1'b1;
        access <= 1'b1;
        wr_en <= write;
        addr <= REG_BASE | bus_addr_t'(ofs);
        bytesel <= sel;
        data_in <= wdata;
        waited = 0;
        @(negedge clk);
        while (!ack) begin
            if (waited > ACK_TIMEOUT)
                stop_on_failure("the register block never raised ack");
            waited++;
            @(negedge clk);
        end
        check_value("ack_latency", waited, 1);
        rdata = data_out;
        @(posedge clk);
        cs <= 1'b0;
        access <= 1'b0;
        wr_en <= 1'b0;
    endtask

    task automatic bus_write(input logic [2:0] ofs, input logic [1:0] sel, input bus_data_t value);
        bus_data_t unused;
        bus_cycle(1'b1, ofs, sel, value, unused);
    endtask

    task automatic bus_read(input logic [2:0] ofs, input logic [1:0] sel,
                            output bus_data_t value);
        bus_cycle(1'b0, ofs, sel, 16'h0000, value);
    endtask

    task automatic write_mode_color(input logic [1:0] sel, input bus_data_t value);
        bus_write(REG_OFS_MODE, sel, value);
        if (sel[0])
            mode_model = value[7:0] & 8'h0b;
        if (sel[1])
            color_model = value[15:8] & 8'h3f;
    endtask

    task automatic check_mode_color();
        bus_data_t rdata;
        bus_read(REG_OFS_MODE, 2'b11, rdata);
        check_value("mode_color", rdata, {color_model, mode_model});
        bus_read(REG_OFS_MODE, 2'b01, rdata);
        check_value("mode_only", rdata, {8'h00, mode_model});
        @(negedge clk);
        check_value("graphics_enabled", graphics_enabled, mode_model[1]);
        check_value("bright_colors", bright_colors, color_model[4]);
        check_value("palette_sel", palette_sel, color_model[5]);
    endtask

    // a word write sets the index and steers the value byte to it
    task automatic write_index_value(input crtc_index_t idx, input reg_byte_t value);
        bus_write(REG_OFS_INDEX, 2'b11, {value, 4'h0, idx});
        index_model = idx;
        crtc_model[idx] = value & index_mask(idx);
    endtask

    task automatic check_index_value();
        bus_data_t rdata;
        bus_read(REG_OFS_INDEX, 2'b11, rdata);
        check_value("index_value", rdata, {crtc_model[index_model], 4'h0, index_model});
        bus_read(REG_OFS_INDEX, 2'b10, rdata);
        check_value("value_only", rdata, {crtc_model[index_model], 8'h00});
    endtask

    task automatic wait_output(input string name, input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (((name == "vsync") ? vsync : display_enable) !== level) begin
            if (cycles > FRAME_TIMEOUT)
                stop_on_failure({"timed out waiting for ", name});
            cycles++;
            @(negedge clk);
        end
    endtask

    // walks the visible pixels of the next frame in raster order
    task automatic capture_frame(output int cursor_pixels);
        int count;
        int cycles;
        int col_n;
        int line_n;
        logic hit;
        wait_output("vsync", 1'b1);
        wait_output("vsync", 1'b0);
        wait_output("display_enable", 1'b1);
        count = 0;
        cycles = 0;
        cursor_pixels = 0;
        while (count < VISIBLE_PIXELS) begin
            if (display_enable) begin
                col_n = count % H_VISIBLE;
                line_n = count / H_VISIBLE;
                hit = ((line_n / CHAR_HEIGHT) * H_VISIBLE + col_n == CURSOR_CELL) &&
                      (line_n % CHAR_HEIGHT >= CURSOR_START) &&
                      (line_n % CHAR_HEIGHT <= CURSOR_END);
                if (hit && pixel_color == CURSOR_COLOR)
                    cursor_pixels++;
                else
                    check_value("pixel_color", pixel_color, color_model[3:0]);
                count++;
            end
            if (cycles > FRAME_TIMEOUT)
                stop_on_failure("the visible area of a frame never completed");
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic test_reset_values();
        bus_data_t rdata;
        check_value("ack", ack, 0);
        bus_read(REG_OFS_MODE, 2'b11, rdata);
        check_value("mode_color", rdata, 16'h0000);
        bus_read(REG_OFS_INDEX, 2'b11, rdata);
        check_value("index_value", rdata, 16'h0000);
    endtask

    task automatic test_register_readback();
        crtc_index_t known [4];
        known = '{IDX_CURSOR_START, IDX_CURSOR_END, IDX_CURSOR_HI, IDX_CURSOR_LO};
        write_mode_color(2'b10, {reg_byte_t'($urandom()), 8'h00});
        check_mode_color();
        foreach (known[i]) begin
            write_index_value(known[i], reg_byte_t'($urandom()));
            check_index_value();
        end
        for (int i = 0; i < 16; i++) begin
            write_index_value(crtc_index_t'(i), reg_byte_t'($urandom()));
            check_index_value();
        end
        // index byte alone, the stored cursor registers must survive
        foreach (known[i]) begin
            bus_write(REG_OFS_INDEX, 2'b01, {reg_byte_t'($urandom()), 4'h0, known[i]});
            index_model = known[i];
            check_index_value();
        end
        write_mode_color(2'b01, bus_data_t'($urandom()));
        check_mode_color();
        write_mode_color(2'b10, bus_data_t'($urandom()));
        check_mode_color();
    endtask

    task automatic test_mode_ports();
        repeat (4) begin
            write_mode_color(2'b11, bus_data_t'($urandom()));
            check_mode_color();
        end
    endtask

    task automatic test_status();
        bus_data_t rdata;
        int delay;
        wait_output("vsync", 1'b0);
        wait_output("vsync", 1'b1);
        bus_read(REG_OFS_STATUS, 2'b01, rdata);
        check_value("status_vsync", rdata[3], 1);
        check_value("status_high_byte", rdata[15:8], 0);
        wait_output("display_enable", 1'b1);
        wait_output("display_enable", 1'b0);
        // hsync rises where the sync window starts inside the horizontal blanking
        delay = 0;
        while (!hsync) begin
            if (delay > H_TOTAL)
                stop_on_failure("hsync never rose after the visible part of a line");
            delay++;
            @(negedge clk);
        end
        check_value("hsync_offset", delay, H_SYNC_START - H_VISIBLE);
        bus_read(REG_OFS_STATUS, 2'b01, rdata);
        check_value("status_blank", rdata[0], 1);
        check_value("status_no_vsync", rdata[3], 0);
    endtask

    task automatic test_cursor_frame();
        int shown;
        color_t background;
        background = color_t'($urandom_range(0, 14));
        write_mode_color(2'b11, {2'b00, 2'($urandom()), background, 8'h09});
        write_index_value(IDX_CURSOR_START, {2'b00, CURSOR_STEADY, 1'b0, 3'(CURSOR_START)});
        write_index_value(IDX_CURSOR_END, reg_byte_t'(CURSOR_END));
        write_index_value(IDX_CURSOR_HI, 8'h00);
        write_index_value(IDX_CURSOR_LO, reg_byte_t'(CURSOR_CELL));
        capture_frame(shown);
        check_value("cursor_pixels", shown, CURSOR_END - CURSOR_START + 1);
    endtask

    task automatic test_cursor_modes();
        int shown;
        int shown_frames;
        int hidden_frames;
        write_index_value(IDX_CURSOR_START, {2'b00, CURSOR_OFF, 1'b0, 3'(CURSOR_START)});
        capture_frame(shown);
        check_value("cursor_off_pixels", shown, 0);
        write_index_value(IDX_CURSOR_START, {2'b00, CURSOR_BLINK, 1'b0, 3'(CURSOR_START)});
        shown_frames = 0;
        hidden_frames = 0;
        repeat (16) begin
            capture_frame(shown);
            if (shown == 0) begin
                hidden_frames++;
            end else begin
                check_value("blink_pixels", shown, CURSOR_END - CURSOR_START + 1);
                shown_frames++;
            end
        end
        check_value("blink_shown_frames", shown_frames > 0, 1);
        check_value("blink_hidden_frames", hidden_frames > 0, 1);
    endtask

    initial begin
        void'($urandom(32'h7c02_7474));
        reset <= 1'b1;
        cs <= 1'b0;
        access <= 1'b0;
        wr_en <= 1'b0;
        addr <= '0;
        bytesel <= 2'b00;
        data_in <= '0;
        mode_model = '0;
        color_model = '0;
        index_model = '0;
        foreach (crtc_model[i])
            crtc_model[i] = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_reset_values();
        test_register_readback();
        test_mode_ports();
        test_status();
        test_cursor_frame();
        test_cursor_modes();
        if (u_display_top.u_display_asserts.failures != 0) begin
            stop_on_failure("a concurrent assertion on the display outputs failed");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* test/display_asserts.sv */
module display_asserts
    import video_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic cs,
    input logic access,
    input logic ack,
    input logic hsync,
    input logic display_enable,
    input color_t pixel_color
);

    int failures = 0;

    // every access cycle is answered on the following clock
    assert property (@(posedge clk) disable iff (reset) ack == $past(cs && access))
        else begin
            $error("ack does not follow cs and access by one clock");
            failures++;
        end

    assert property (@(posedge clk) disable iff (reset)
                     $rose(hsync) |-> hsync [*H_SYNC_LEN] ##1 !hsync)
        else begin
            $error("hsync pulse has the wrong length");
            failures++;
        end

    // blanked pixels are always black
    assert property (@(posedge clk) disable iff (reset) !display_enable |-> pixel_color == '0)
        else begin
            $error("pixel_color is not zero while display_enable is low");
            failures++;
        end

endmodule

bind display_top display_asserts u_display_asserts (
    .clk(clk),
    .reset(reset),
    .cs(cs),
    .access(access),
    .ack(ack),
    .hsync(hsync),
    .display_enable(display_enable),
    .pixel_color(pixel_color)
);

/* verilog/display_top.sv */
module display_top
    import crtc_regs_pkg::*, video_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic cs,
    input logic access,
    input logic wr_en,
    input bus_addr_t addr,
    input logic [1:0] bytesel,
    input bus_data_t data_in,
    output bus_data_t data_out,
    output logic ack,
    output logic hsync,
    output logic vsync,
    output logic display_enable,
    output color_t pixel_color,
    output logic graphics_enabled,
    output logic bright_colors,
    output logic palette_sel
);

    col_t col;
    line_t line;
    logic visible;
    logic blank;
    logic hsync_raw;
    logic vsync_raw;
    logic [3:0] frame_count;

    display_cfg_if u_cfg ();

    crtc_registers u_crtc_registers (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .access(access),
        .wr_en(wr_en),
        .addr(addr),
        .bytesel(bytesel),
        .data_in(data_in),
        .blank(blank),
        .vsync_raw(vsync_raw),
        .data_out(data_out),
        .ack(ack),
        .graphics_enabled(graphics_enabled),
        .bright_colors(bright_colors),
        .palette_sel(palette_sel),
        .cfg(u_cfg.regs)
    );

    raster_timing u_raster_timing (
        .clk(clk),
        .reset(reset),
        .col(col),
        .line(line),
        .visible(visible),
        .blank(blank),
        .hsync_raw(hsync_raw),
        .vsync_raw(vsync_raw),
        .frame_count(frame_count)
    );

    cursor_color u_cursor_color (
        .clk(clk),
        .reset(reset),
        .col(col),
        .line(line),
        .visible(visible),
        .hsync_raw(hsync_raw),
        .vsync_raw(vsync_raw),
        .frame_count(frame_count),
        .cfg(u_cfg.video),
        .hsync(hsync),
        .vsync(vsync),
        .display_enable(display_enable),
        .pixel_color(pixel_color)
    );

endmodule

/* crtc/cursor_color.sv */
module cursor_color
    import crtc_regs_pkg::*, video_pkg::*;
(
    input logic clk,
    input logic reset,
    input col_t col,
    input line_t line,
    input logic visible,
    input logic hsync_raw,
    input logic vsync_raw,
    input logic [3:0] frame_count,
    display_cfg_if.video cfg,
    output logic hsync,
    output logic vsync,
    output logic display_enable,
    output color_t pixel_color
);

    line_t row;
    scan_t scan;
    cursor_addr_t cell_addr;
    logic mode_on;
    logic cursor_hit;
    logic text_on;
    color_t next_color;

    assign row = line_t'(line / CHAR_HEIGHT);
    assign scan = scan_t'(line % CHAR_HEIGHT);
    assign cell_addr = cursor_addr_t'(row) * cursor_addr_t'(H_VISIBLE) + cursor_addr_t'(col);

    // blink modes show the cursor for half of each blink period
    always_comb begin
        case (cfg.cursor_mode)
            CURSOR_STEADY: mode_on = 1'b1;
            CURSOR_OFF: mode_on = 1'b0;
            default: mode_on = frame_count[BLINK_BIT];
        endcase
    end

    assign cursor_hit = mode_on && (cell_addr == cfg.cursor_pos) &&
                        (scan >= cfg.cursor_scan_start) && (scan <= cfg.cursor_scan_end);

    assign text_on = visible & cfg.display_enabled & cfg.text_enabled;
    assign next_color = !text_on ? color_t'(0) : cursor_hit ? CURSOR_COLOR : cfg.background_color;

    // every output takes the same single register stage so they stay aligned
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            display_enable <= 1'b0;
            pixel_color <= '0;
        end else begin
            hsync <= hsync_raw;
            vsync <= vsync_raw;
            display_enable <= visible;
            pixel_color <= next_color;
        end
    end

endmodule

/* crtc/raster_timing.sv */
module raster_timing
    import video_pkg::*;
(
    input logic clk,
    input logic reset,
    output col_t col,
    output line_t line,
    output logic visible,
    output logic blank,
    output logic hsync_raw,
    output logic vsync_raw,
    output logic [3:0] frame_count
);

    logic line_end;
    logic frame_end;

    assign line_end = col == col_t'(H_TOTAL - 1);
    assign frame_end = line_end && (line == line_t'(V_TOTAL - 1));

    // column advances every clock, the line at the end of each row of clocks
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col <= '0;
            line <= '0;
            frame_count <= '0;
        end else begin
            if (line_end) begin
                col <= '0;
            end else begin
                col <= col + 6'd1;
            end

            if (frame_end) begin
                line <= '0;
                frame_count <= frame_count + 4'd1;
            end else if (line_end) begin
                line <= line + 5'd1;
            end
        end
    end

    assign visible = (col < H_VISIBLE) && (line < V_VISIBLE);
    assign blank = ~visible;

    // sync windows sit inside the blanking interval
    assign hsync_raw = (col >= H_SYNC_START) && (col < H_SYNC_START + H_SYNC_LEN);
    assign vsync_raw = (line >= V_SYNC_START) && (line < V_SYNC_START + V_SYNC_LEN);

endmodule

/* crtc/crtc_registers.sv */
module crtc_registers
    import crtc_regs_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic cs,
    input logic access,
    input logic wr_en,
    input bus_addr_t addr,
    input logic [1:0] bytesel,
    input bus_data_t data_in,
    input logic blank,
    input logic vsync_raw,
    output bus_data_t data_out,
    output logic ack,
    output logic graphics_enabled,
    output logic bright_colors,
    output logic palette_sel,
    display_cfg_if.regs cfg
);

    logic reg_access;
    logic ofs_index;
    logic ofs_mode;
    logic ofs_status;
    logic sel_index;
    logic sel_value;
    logic sel_mode;
    logic sel_color;
    logic sel_status;
    crtc_index_t active_index;
    crtc_index_t index;
    reg_byte_t index_value;
    reg_byte_t status;

    assign reg_access = cs & access;

    assign ofs_index = addr[2:0] == REG_OFS_INDEX;
    assign ofs_mode = addr[2:0] == REG_OFS_MODE;
    assign ofs_status = addr[2:0] == REG_OFS_STATUS;

    // low byte lane selects the first register of each pair, high lane the second
    assign sel_index = reg_access & ofs_index & bytesel[0];
    assign sel_value = reg_access & ofs_index & bytesel[1];
    assign sel_mode = reg_access & ofs_mode & bytesel[0];
    assign sel_color = reg_access & ofs_mode & bytesel[1];
    assign sel_status = reg_access & ofs_status & bytesel[0];

    // a word write of index and value steers the value with the new index
    assign index = (wr_en & sel_index) ? data_in[3:0] : active_index;

    assign status = {4'b0, vsync_raw, 2'b0, blank};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_index <= '0;
        end else if (wr_en & sel_index) begin
            active_index <= data_in[3:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg.cursor_mode <= CURSOR_STEADY;
            cfg.cursor_scan_start <= '0;
            cfg.cursor_scan_end <= '0;
            cfg.cursor_pos <= '0;
        end else if (wr_en & sel_value) begin
            case (index)
                IDX_CURSOR_START: begin
                    cfg.cursor_mode <= cursor_mode_t'(data_in[13:12]);
                    cfg.cursor_scan_start <= data_in[10:8];
                end
                IDX_CURSOR_END: cfg.cursor_scan_end <= data_in[10:8];
                IDX_CURSOR_HI: cfg.cursor_pos[14:8] <= data_in[14:8];
                IDX_CURSOR_LO: cfg.cursor_pos[7:0] <= data_in[15:8];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg.display_enabled <= 1'b0;
            graphics_enabled <= 1'b0;
            cfg.text_enabled <= 1'b0;
            palette_sel <= 1'b0;
            bright_colors <= 1'b0;
            cfg.background_color <= '0;
        end else begin
            if (wr_en & sel_mode) begin
                cfg.display_enabled <= data_in[3];
                graphics_enabled <= data_in[1];
                cfg.text_enabled <= data_in[0];
            end
            if (wr_en & sel_color) begin
                palette_sel <= data_in[13];
                bright_colors <= data_in[12];
                cfg.background_color <= data_in[11:8];
            end
        end
    end

    always_comb begin
        case (index)
            IDX_CURSOR_START: index_value = {2'b0, cfg.cursor_mode, 1'b0, cfg.cursor_scan_start};
            IDX_CURSOR_END: index_value = {5'b0, cfg.cursor_scan_end};
            IDX_CURSOR_HI: index_value = {1'b0, cfg.cursor_pos[14:8]};
            IDX_CURSOR_LO: index_value = cfg.cursor_pos[7:0];
            default: index_value = '0;
        endcase
    end

    // unselected byte lanes and idle cycles read back as zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_out <= '0;
        end else begin
            data_out <= '0;
            if (!wr_en) begin
                if (sel_index)
                    data_out[7:0] <= {4'b0, active_index};
                if (sel_mode)
                    data_out[7:0] <= {4'b0, cfg.display_enabled, 1'b0, graphics_enabled,
                                      cfg.text_enabled};
                if (sel_status)
                    data_out[7:0] <= status;
                if (sel_value)
                    data_out[15:8] <= index_value;
                if (sel_color)
                    data_out[15:8] <= {2'b0, palette_sel, bright_colors, cfg.background_color};
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= reg_access;
        end
    end

endmodule

/* common/display_cfg_if.sv */
interface display_cfg_if
    import crtc_regs_pkg::*, video_pkg::*;
();

    cursor_mode_t cursor_mode;
    scan_t cursor_scan_start;
    scan_t cursor_scan_end;
    cursor_addr_t cursor_pos;
    logic display_enabled;
    logic text_enabled;
    color_t background_color;

    // the register block owns every setting
    modport regs (
        output cursor_mode, cursor_scan_start, cursor_scan_end, cursor_pos,
        output display_enabled, text_enabled, background_color
    );

    // the display pipeline only reads them
    modport video (
        input cursor_mode, cursor_scan_start, cursor_scan_end, cursor_pos,
        input display_enabled, text_enabled, background_color
    );

endinterface

/* common/video_pkg.sv */
package video_pkg;

    typedef logic [5:0] col_t;
    typedef logic [4:0] line_t;
    typedef logic [2:0] scan_t;
    typedef logic [14:0] cursor_addr_t;
    typedef logic [3:0] color_t;

    // horizontal raster in character clocks
    localparam int H_VISIBLE = 32;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_LEN = 4;
    localparam int H_TOTAL = 40;

    // vertical raster in scan lines
    localparam int V_VISIBLE = 24;
    localparam int V_SYNC_START = 26;
    localparam int V_SYNC_LEN = 2;
    localparam int V_TOTAL = 30;

    // scan lines per character row
    localparam int CHAR_HEIGHT = 8;

    // frame counter bit that drives the cursor blink
    localparam int BLINK_BIT = 3;

    // bright white, drawn over the cell background
    localparam color_t CURSOR_COLOR = 4'hf;

endpackage

/* common/crtc_regs_pkg.sv */
package crtc_regs_pkg;

    // bus side types
    typedef logic [18:0] bus_addr_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [7:0] reg_byte_t;
    typedef logic [3:0] crtc_index_t;

    // word offsets inside the register window, decoded from the low address bits
    localparam logic [2:0] REG_OFS_INDEX = 3'd2;
    localparam logic [2:0] REG_OFS_MODE = 3'd4;
    localparam logic [2:0] REG_OFS_STATUS = 3'd5;

    // CRTC register numbers reached through the index/value pair
    localparam crtc_index_t IDX_CURSOR_START = 4'ha;
    localparam crtc_index_t IDX_CURSOR_END = 4'hb;
    localparam crtc_index_t IDX_CURSOR_HI = 4'he;
    localparam crtc_index_t IDX_CURSOR_LO = 4'hf;

    // both blink encodings blink at the same rate
    typedef enum logic [1:0] {
        CURSOR_STEADY = 2'b00,
        CURSOR_OFF = 2'b01,
        CURSOR_BLINK = 2'b10,
        CURSOR_BLINK_ALT = 2'b11
    } cursor_mode_t;

endpackage
